/* src/backend_pkg.sv */
`default_nettype none

package backend_pkg;

    localparam int xlen           = 32;
    localparam int dmem_words     = 256;
    localparam int dmem_addr_bits = 8;   // word index into the data SRAM
    localparam int reg_index_bits = 5;

    // major opcodes for the memory instructions
    localparam logic [6:0] opcode_load  = 7'b0000011;
    localparam logic [6:0] opcode_store = 7'b0100011;

    typedef enum logic [1:0] {
        kind_alu   = 2'd0,
        kind_load  = 2'd1,
        kind_store = 2'd2
    } mem_kind_e;

    // funct3 of loads and stores
    typedef enum logic [2:0] {
        lsw_byte   = 3'b000,
        lsw_half   = 3'b001,
        lsw_word   = 3'b010,
        lsw_byte_u = 3'b100,
        lsw_half_u = 3'b101
    } ls_width_e;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_s;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } s_fmt_s;

    // one instruction word, seen as a load or as a store
    typedef union packed {
        i_fmt_s i;
        s_fmt_s s;
    } rv_inst_u;

endpackage

`default_nettype wire

/* src/stage_if.sv */
`timescale 1ns/1ps
`default_nettype none

// execute record into the MEM stage
interface mem_bus_if;
    import backend_pkg::*;

    logic                      valid;
    logic                      ready;
    mem_kind_e                 kind;
    rv_inst_u                  inst;
    logic [xlen-1:0]           pc;
    logic [xlen-1:0]           alu_result;
    logic [xlen-1:0]           store_data;
    logic [reg_index_bits-1:0] wreg_index;
    logic                      wreg_en;

    modport producer (output valid, kind, inst, pc, alu_result, store_data,
                      wreg_index, wreg_en, input ready);
    modport consumer (input valid, kind, inst, pc, alu_result, store_data,
                      wreg_index, wreg_en, output ready);
endinterface

// MEM record into the WB stage
interface wb_bus_if;
    import backend_pkg::*;

    logic                      valid;
    logic                      ready;
    mem_kind_e                 kind;
    ls_width_e                 width;
    logic [1:0]                byte_offset;
    logic [xlen-1:0]           pc;
    logic [xlen-1:0]           result;
    logic [reg_index_bits-1:0] wreg_index;
    logic                      wreg_en;

    modport producer (output valid, kind, width, byte_offset, pc, result,
                      wreg_index, wreg_en, input ready);
    modport consumer (input valid, kind, width, byte_offset, pc, result,
                      wreg_index, wreg_en, output ready);
endinterface

`default_nettype wire

/* src/ex_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_capture (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   in_valid,
    output logic                                   in_ready,
    input  logic [backend_pkg::xlen-1:0]           in_inst,
    input  logic [backend_pkg::xlen-1:0]           in_pc,
    input  logic [backend_pkg::xlen-1:0]           in_alu_result,
    input  logic [backend_pkg::xlen-1:0]           in_store_data,
    input  logic [backend_pkg::reg_index_bits-1:0] in_wreg_index,
    input  logic                                   in_wreg_en,
    mem_bus_if.producer                            mb
);
    import backend_pkg::*;

    rv_inst_u  in_word;
    mem_kind_e in_kind;
    logic      load_en;
    logic      fire;

    assign in_word = in_inst;
    assign in_ready = mb.ready;   // ready passes straight through
    assign load_en = in_valid & mb.ready;
    assign fire = mb.valid & mb.ready;

    // kind from the major opcode
    always_comb begin
        if (in_word.i.opcode == opcode_load) begin
            in_kind = kind_load;
        end else if (in_word.i.opcode == opcode_store) begin
            in_kind = kind_store;
        end else begin
            in_kind = kind_alu;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mb.valid <= 1'b0;
        end else if (load_en) begin
            mb.valid <= 1'b1;
        end else if (fire) begin
            mb.valid <= 1'b0;    // drained, nothing new behind it
        end
    end

    // payload, no reset needed
    always_ff @(posedge clk) begin
        if (load_en) begin
            mb.kind       <= in_kind;
            mb.inst       <= in_word;
            mb.pc         <= in_pc;
            mb.alu_result <= in_alu_result;
            mb.store_data <= in_store_data;
            mb.wreg_index <= in_wreg_index;
            mb.wreg_en    <= in_wreg_en & (in_kind != kind_store);  // stores never write back
        end
    end

endmodule

`default_nettype wire

/* src/mem_access.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_access (
    input  logic                                   clk,
    input  logic                                   rst_n,
    mem_bus_if.consumer                            mb,
    wb_bus_if.producer                             wb,
    output logic [backend_pkg::xlen-1:0]           addr,
    output logic                                   en,
    output logic                                   we,
    output logic [3:0]                             wmask,
    output logic [backend_pkg::xlen-1:0]           wdata,
    output logic                                   bypass_valid,
    output logic [backend_pkg::reg_index_bits-1:0] bypass_index,
    output logic [backend_pkg::xlen-1:0]           bypass_data
);
    import backend_pkg::*;

    ls_width_e                 width;
    logic [1:0]                offset;
    logic                      xfer;
    logic                      is_load;
    logic                      is_store;
    logic [3:0]                lane_mask;
    logic [reg_index_bits-1:0] dest_index;

    assign width    = ls_width_e'(mb.inst.s.funct3);  // same field in both views
    assign offset   = mb.alu_result[1:0];
    assign xfer     = mb.valid & wb.ready;
    assign is_load  = (mb.kind == kind_load);
    assign is_store = (mb.kind == kind_store);

    // loads name their destination in rd
    assign dest_index = is_load ? mb.inst.i.rd : mb.wreg_index;

    assign mb.ready = wb.ready;

    // byte lanes touched by the access
    always_comb begin
        case (width)
            lsw_byte, lsw_byte_u: lane_mask = 4'b0001 << offset;
            lsw_half, lsw_half_u: lane_mask = offset[1] ? 4'b1100 : 4'b0011;
            default:              lane_mask = 4'b1111;
        endcase
    end

    // replicate store data so every lane carries the right bytes
    always_comb begin
        case (width)
            lsw_byte, lsw_byte_u: wdata = {4{mb.store_data[7:0]}};
            lsw_half, lsw_half_u: wdata = {2{mb.store_data[15:0]}};
            default:              wdata = mb.store_data;
        endcase
    end

    assign addr  = mb.alu_result;
    assign en    = xfer & (is_load | is_store);  // once per item, on transfer
    assign wmask = (xfer & is_store) ? lane_mask : 4'b0000;
    assign we    = |wmask;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.valid <= 1'b0;
        end else if (xfer) begin
            wb.valid <= 1'b1;
        end else if (wb.valid & wb.ready) begin
            wb.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            wb.kind        <= mb.kind;
            wb.pc          <= mb.pc;
            wb.result      <= mb.alu_result;
            wb.wreg_index  <= dest_index;
            wb.wreg_en     <= mb.wreg_en;
            wb.width       <= is_load ? width : lsw_word;  // only loads need extraction
            wb.byte_offset <= is_load ? offset : 2'b00;
        end
    end

    // a load value is not known yet in MEM
    assign bypass_valid = mb.valid & mb.wreg_en & (mb.kind == kind_alu);
    assign bypass_index = mb.wreg_index;
    assign bypass_data  = mb.alu_result;

endmodule

`default_nettype wire

/* src/data_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_sram (
    input  logic                                   clk,
    input  logic                                   en,
    input  logic                                   we,
    input  logic [3:0]                             wmask,
    input  logic [backend_pkg::dmem_addr_bits-1:0] addr,
    input  logic [backend_pkg::xlen-1:0]           wdata,
    output logic [backend_pkg::xlen-1:0]           rdata
);
    import backend_pkg::*;

    logic [xlen-1:0] mem [dmem_words];

    // start from a clean array
    initial begin
        for (int i = 0; i < dmem_words; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (en && we) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) begin
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* src/load_align_wb.sv */
`timescale 1ns/1ps
`default_nettype none

module load_align_wb (
    input  logic                                   clk,
    input  logic                                   rst_n,
    wb_bus_if.consumer                             wb,
    input  logic [backend_pkg::xlen-1:0]           rdata,
    output logic                                   out_valid,
    input  logic                                   out_ready,
    output logic                                   rf_we,
    output logic [backend_pkg::reg_index_bits-1:0] rf_waddr,
    output logic [backend_pkg::xlen-1:0]           rf_wdata,
    output logic [backend_pkg::xlen-1:0]           retire_pc
);
    import backend_pkg::*;

    logic            fresh;       // last edge let a new item in
    logic            first_cycle;
    logic [xlen-1:0] rdata_hold;
    logic [xlen-1:0] load_word;
    logic [xlen-1:0] shifted;
    logic [xlen-1:0] load_value;

    assign wb.ready = out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fresh <= 1'b0;
        end else begin
            fresh <= out_ready;
        end
    end

    assign first_cycle = wb.valid & fresh;

    always_ff @(posedge clk) begin
        if (first_cycle) begin
            rdata_hold <= rdata;
        end
    end

    assign load_word = first_cycle ? rdata : rdata_hold;
    assign shifted = load_word >> {wb.byte_offset, 3'b000};

    // extract and extend
    always_comb begin
        case (wb.width)
            lsw_byte:   load_value = {{24{shifted[7]}}, shifted[7:0]};
            lsw_half:   load_value = {{16{shifted[15]}}, shifted[15:0]};
            lsw_byte_u: load_value = {24'h0, shifted[7:0]};
            lsw_half_u: load_value = {16'h0, shifted[15:0]};
            default:    load_value = load_word;
        endcase
    end

    assign out_valid = wb.valid;
    assign rf_we     = wb.valid & out_ready & wb.wreg_en & (wb.kind != kind_store);
    assign rf_waddr  = wb.wreg_index;
    assign rf_wdata  = (wb.kind == kind_load) ? load_value : wb.result;
    assign retire_pc = wb.pc;

endmodule

`default_nettype wire

/* src/mem_backend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_backend_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   in_valid,
    output logic                                   in_ready,
    input  logic [backend_pkg::xlen-1:0]           in_inst,
    input  logic [backend_pkg::xlen-1:0]           in_pc,
    input  logic [backend_pkg::xlen-1:0]           in_alu_result,
    input  logic [backend_pkg::xlen-1:0]           in_store_data,
    input  logic [backend_pkg::reg_index_bits-1:0] in_wreg_index,
    input  logic                                   in_wreg_en,
    output logic                                   out_valid,
    input  logic                                   out_ready,
    output logic                                   rf_we,
    output logic [backend_pkg::reg_index_bits-1:0] rf_waddr,
    output logic [backend_pkg::xlen-1:0]           rf_wdata,
    output logic [backend_pkg::xlen-1:0]           retire_pc,
    output logic                                   bypass_valid,
    output logic [backend_pkg::reg_index_bits-1:0] bypass_index,
    output logic [backend_pkg::xlen-1:0]           bypass_data
);
    import backend_pkg::*;

    logic [xlen-1:0] sram_addr;
    logic            sram_en;
    logic            sram_we;
    logic [3:0]      sram_wmask;
    logic [xlen-1:0] sram_wdata;
    logic [xlen-1:0] sram_rdata;

    mem_bus_if mem_bus0 ();
    wb_bus_if  wb_bus0 ();

    ex_capture ex_capture0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_inst       (in_inst),
        .in_pc         (in_pc),
        .in_alu_result (in_alu_result),
        .in_store_data (in_store_data),
        .in_wreg_index (in_wreg_index),
        .in_wreg_en    (in_wreg_en),
        .mb            (mem_bus0.producer)
    );

    mem_access mem_access0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .mb           (mem_bus0.consumer),
        .wb           (wb_bus0.producer),
        .addr         (sram_addr),
        .en           (sram_en),
        .we           (sram_we),
        .wmask        (sram_wmask),
        .wdata        (sram_wdata),
        .bypass_valid (bypass_valid),
        .bypass_index (bypass_index),
        .bypass_data  (bypass_data)
    );

    // word index from the byte address
    data_sram data_sram0 (
        .clk   (clk),
        .en    (sram_en),
        .we    (sram_we),
        .wmask (sram_wmask),
        .addr  (sram_addr[dmem_addr_bits+1:2]),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

    load_align_wb load_align_wb0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb        (wb_bus0.consumer),
        .rdata     (sram_rdata),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .rf_we     (rf_we),
        .rf_waddr  (rf_waddr),
        .rf_wdata  (rf_wdata),
        .retire_pc (retire_pc)
    );

endmodule

`default_nettype wire

/* verif/tb_mem_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_backend;
    import backend_pkg::*;

    logic                      clk;
    logic                      rst_n;
    logic                      in_valid;
    logic                      in_ready;
    logic [xlen-1:0]           in_inst;
    logic [xlen-1:0]           in_pc;
    logic [xlen-1:0]           in_alu_result;
    logic [xlen-1:0]           in_store_data;
    logic [reg_index_bits-1:0] in_wreg_index;
    logic                      in_wreg_en;
    logic                      out_valid;
    logic                      out_ready;
    logic                      rf_we;
    logic [reg_index_bits-1:0] rf_waddr;
    logic [xlen-1:0]           rf_wdata;
    logic [xlen-1:0]           retire_pc;
    logic                      bypass_valid;
    logic [reg_index_bits-1:0] bypass_index;
    logic [xlen-1:0]           bypass_data;

    logic [7:0]                mem_model [1024];  // byte image of the SRAM
    logic [xlen-1:0]           exp_pc [$];
    logic                      exp_we [$];
    logic [reg_index_bits-1:0] exp_waddr [$];
    logic [xlen-1:0]           exp_wdata [$];
    logic                      shadow_valid;      // item held in MEM
    logic                      shadow_wb_valid;   // item held in WB
    logic                      shadow_bypass;
    logic [reg_index_bits-1:0] shadow_index;
    logic [xlen-1:0]           shadow_data;
    logic [xlen-1:0]           next_pc;
    ls_width_e                 sub_widths [4] = '{lsw_byte, lsw_half, lsw_byte_u, lsw_half_u};
    int                        errors;
    int                        checks;
    int                        tests;
    int                        failed_tests;
    int                        stores_in;
    int                        store_writes;
    bit                        timed_out;

    mem_backend_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_word(input string name, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_index(input string name, input logic [reg_index_bits-1:0] got,
                               input logic [reg_index_bits-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_retire(input logic [xlen-1:0] pc_got, input logic [xlen-1:0] pc_exp,
                                input logic we_got, input logic we_exp);
        checks++;
        if (pc_got !== pc_exp || we_got !== we_exp) begin
            errors++;
            $display("FAILED t=%0t retire_pc/rf_we: got %h/%b, expected %h/%b",
                     $time, pc_got, we_got, pc_exp, we_exp);
        end
    endtask

    // little endian byte model, sign or zero extended per funct3
    function automatic logic [xlen-1:0] load_model(input logic [9:0] a, input ls_width_e w);
        case (w)
            lsw_byte:   return {{24{mem_model[a][7]}}, mem_model[a]};
            lsw_byte_u: return {24'h0, mem_model[a]};
            lsw_half:   return {{16{mem_model[a+1][7]}}, mem_model[a+1], mem_model[a]};
            lsw_half_u: return {16'h0, mem_model[a+1], mem_model[a]};
            default:    return {mem_model[a+3], mem_model[a+2], mem_model[a+1], mem_model[a]};
        endcase
    endfunction

    task automatic store_model(input logic [9:0] a, input ls_width_e w,
                               input logic [xlen-1:0] d);
        int n;
        n = (w == lsw_byte) ? 1 : (w == lsw_half) ? 2 : 4;
        for (int k = 0; k < n; k++) begin
            mem_model[a + k] = d[8*k +: 8];
        end
    endtask

    function automatic rv_inst_u load_inst(input ls_width_e w, input logic [4:0] rd);
        rv_inst_u u;
        u = $urandom;               // don't-care fields stay random
        u.i.opcode = opcode_load;
        u.i.funct3 = w;
        u.i.rd     = rd;
        return u;
    endfunction

    function automatic rv_inst_u store_inst(input ls_width_e w);
        rv_inst_u u;
        u = $urandom;
        u.s.opcode = opcode_store;
        u.s.funct3 = w;
        return u;
    endfunction

    // aligned address inside a 32 byte window
    function automatic logic [xlen-1:0] window_addr(input ls_width_e w);
        logic [xlen-1:0] a;
        a = 32'h100 + {27'h0, 3'($urandom), 2'b00};
        if (w == lsw_byte || w == lsw_byte_u) a[1:0] = 2'($urandom);
        else if (w == lsw_half || w == lsw_half_u) a[1] = 1'($urandom);
        return a;
    endfunction

    task automatic next_edge();
        @(posedge clk);
        #2;
    endtask

    // sample just before the edge, once inputs and outputs have settled
    task automatic observe(output bit accepted);
        rv_inst_u                  inst;
        bit                        is_ld;
        bit                        is_st;
        logic [xlen-1:0]           pc;
        logic                      we;
        logic [reg_index_bits-1:0] waddr;
        logic [xlen-1:0]           wdata;
        #16;
        inst     = in_inst;
        is_ld    = (inst.i.opcode == opcode_load);
        is_st    = (inst.i.opcode == opcode_store);
        accepted = in_valid & in_ready;
        check_flag("in_ready", in_ready, out_ready);
        check_flag("out_valid", out_valid, shadow_wb_valid);
        check_flag("bypass_valid", bypass_valid, shadow_valid & shadow_bypass);
        if (shadow_valid && shadow_bypass) begin
            check_index("bypass_index", bypass_index, shadow_index);
            check_word("bypass_data", bypass_data, shadow_data);
        end
        if (dut0.sram_en && dut0.sram_we) begin
            store_writes++;
        end
        if (out_valid && out_ready && exp_pc.size() == 0) begin
            errors++;
            $display("retire of pc %h with no accepted item left to retire", retire_pc);
        end else if (out_valid && out_ready) begin
            pc    = exp_pc.pop_front();
            we    = exp_we.pop_front();
            waddr = exp_waddr.pop_front();
            wdata = exp_wdata.pop_front();
            check_retire(retire_pc, pc, rf_we, we);
            if (we) begin
                check_index("rf_waddr", rf_waddr, waddr);
                check_word("rf_wdata", rf_wdata, wdata);
            end
        end else begin
            check_flag("rf_we", rf_we, 1'b0);   // no retire, no write
        end
        if (out_ready) begin
            shadow_wb_valid = shadow_valid;   // MEM record moves on
        end
        if (accepted) begin
            shadow_valid  = 1'b1;
            shadow_bypass = !is_ld && !is_st && in_wreg_en;
            shadow_index  = in_wreg_index;
            shadow_data   = in_alu_result;
            if (is_st) begin
                stores_in++;
                store_model(in_alu_result[9:0], ls_width_e'(inst.s.funct3), in_store_data);
            end
            exp_pc.push_back(in_pc);
            exp_we.push_back(in_wreg_en & !is_st);
            exp_waddr.push_back(is_ld ? inst.i.rd : in_wreg_index);
            exp_wdata.push_back(is_ld ? load_model(in_alu_result[9:0], ls_width_e'(inst.i.funct3))
                                      : in_alu_result);
        end else if (out_ready) begin
            shadow_valid = 1'b0;
        end
    endtask

    task automatic send_item(input rv_inst_u inst, input logic [xlen-1:0] alu,
                             input logic [xlen-1:0] sd, input logic [4:0] idx,
                             input logic wen, input bit bp);
        bit accepted;
        int waited;
        if (timed_out) return;
        accepted      = 1'b0;
        waited        = 0;
        in_valid      = 1'b1;
        in_inst       = inst;
        in_pc         = next_pc;
        in_alu_result = alu;
        in_store_data = sd;
        in_wreg_index = idx;
        in_wreg_en    = wen;
        next_pc += 4;
        while (!accepted && waited < 100) begin
            out_ready = bp ? ($urandom % 3 != 0) : 1'b1;
            observe(accepted);
            next_edge();
            waited++;
        end
        in_valid = 1'b0;
        if (!accepted) begin
            timed_out = 1'b1;
            $display("timeout: item at pc %h never accepted", in_pc);
        end
    endtask

    // mode 0 holds out_ready low, 1 high, 2 random
    task automatic idle(input int n, input int mode);
        bit accepted;
        for (int k = 0; k < n; k++) begin
            out_ready = (mode == 2) ? ($urandom % 2 == 1) : (mode == 1);
            observe(accepted);
            next_edge();
        end
    endtask

    task automatic drain();
        int waited;
        bit accepted;
        waited    = 0;
        out_ready = 1'b1;
        while (exp_pc.size() > 0 && waited < 200) begin
            observe(accepted);
            next_edge();
            waited++;
        end
        if (exp_pc.size() > 0) begin
            timed_out = 1'b1;
            $display("timeout: %0d accepted items never retired", exp_pc.size());
        end
    endtask

    task automatic random_item(input bit bp);
        ls_width_e w;
        logic [4:0] rd;
        rd = 5'($urandom);
        case ($urandom % 3)
            0: begin
                w = ls_width_e'(3'($urandom % 3));
                send_item(store_inst(w), window_addr(w), $urandom, rd, 1'($urandom), bp);
            end
            1: begin
                w = ls_width_e'((3'($urandom % 5) == 3'd3) ? lsw_byte_u : 3'($urandom % 3));
                if ($urandom % 5 == 0) w = lsw_half_u;
                send_item(load_inst(w, rd), window_addr(w), $urandom, 5'($urandom),
                          1'($urandom), bp);
            end
            default: send_item(rv_inst_u'(32'h33 | ($urandom & 32'hffff_ff80)),
                               $urandom, $urandom, rd, 1'($urandom), bp);
        endcase
    endtask

    task automatic report_test(input string name, input int mark);
        tests++;
        if (errors != mark || timed_out) failed_tests++;
        $display("test %0d %s: %s", tests, name,
                 (errors == mark && !timed_out) ? "ok" : "failed");
    endtask

    initial begin
        bit         accepted;
        int         mark;
        ls_width_e  w;
        logic [xlen-1:0] a;
        logic [4:0] rd;
        void'($urandom(52));
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_inst = '0;
        in_pc = '0;
        in_alu_result = '0;
        in_store_data = '0;
        in_wreg_index = '0;
        in_wreg_en = 1'b0;
        out_ready = 1'b1;
        next_pc = 32'h1000;
        shadow_valid = 1'b0;
        shadow_wb_valid = 1'b0;
        shadow_bypass = 1'b0;
        for (int k = 0; k < 1024; k++) mem_model[k] = 8'h00;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        mark = errors;
        observe(accepted);
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("rf_we", rf_we, 1'b0);
        next_edge();
        report_test("reset state", mark);

        mark = errors;
        for (int n = 0; n < 24; n++) begin
            send_item(rv_inst_u'(32'h33 | ($urandom & 32'hffff_ff80)), $urandom, $urandom,
                      5'($urandom), 1'($urandom), 1'b0);
            idle($urandom % 2, 1);
        end
        drain();
        report_test("alu pass-through", mark);

        mark = errors;
        for (int n = 0; n < 16; n++) begin
            w  = ls_width_e'(3'($urandom % 3));
            a  = window_addr(w);
            rd = 5'($urandom);
            send_item(store_inst(w), a, $urandom, 5'($urandom), 1'($urandom), 1'b0);
            send_item(load_inst(lsw_word, rd), {a[31:2], 2'b00}, '0, rd, 1'b1, 1'b0);
        end
        drain();
        report_test("store widths then lw", mark);

        mark = errors;
        for (int n = 0; n < 4; n++) begin
            a = window_addr(lsw_word);
            send_item(store_inst(lsw_word), a, $urandom, '0, 1'b0, 1'b0);
            foreach (sub_widths[j]) begin
                for (int off = 0; off < 4; off++) begin
                    rd = 5'($urandom);
                    if ((sub_widths[j] == lsw_half || sub_widths[j] == lsw_half_u)
                        && off % 2 != 0) begin
                        continue;   // halves sit on even offsets only
                    end
                    send_item(load_inst(sub_widths[j], rd), a + off, '0, rd, 1'b1, 1'b0);
                end
            end
        end
        drain();
        report_test("sub-word loads at every offset", mark);

        mark = errors;
        stores_in = 0;
        store_writes = 0;
        for (int n = 0; n < 200; n++) begin
            if ($urandom % 4 == 0) idle(1 + $urandom % 3, 2);
            random_item(1'b1);
        end
        drain();
        check_word("store write count", xlen'(store_writes), xlen'(stores_in));
        report_test("random back-pressure", mark);

        mark = errors;
        send_item(rv_inst_u'(32'h0000_0033), $urandom, '0, 5'd7, 1'b1, 1'b0);
        idle(4, 0);
        send_item(load_inst(lsw_word, 5'd9), 32'h104, '0, 5'd9, 1'b1, 1'b0);
        idle(3, 0);
        drain();
        report_test("bypass while held in mem", mark);

        $display("tests %0d, failed %0d, checks %0d, errors %0d%s", tests, failed_tests,
                 checks, errors, timed_out ? ", run stopped by timeout" : "");
        if (errors == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
src/backend_pkg.sv
src/stage_if.sv
src/ex_capture.sv
src/mem_access.sv
src/data_sram.sv
src/load_align_wb.sv
src/mem_backend_top.sv
verif/tb_mem_backend.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tb_mem_backend \
    -f compile.f -o sim_mem_backend || exit 1
out=$(./obj_dir/sim_mem_backend)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qxF -e '** PASS **' && exit 0 || exit 1
